/* source/txbuf_defs.svh */
// tx buffer fill numbers: buffer geometry, request limits and completion codes
`ifndef TXBUF_DEFS_SVH
`define TXBUF_DEFS_SVH

// on-chip tx buffer
`define BUF_QWORDS          512         // buffer depth in qwords
`define BUF_ADDR_W          9           // buffer write address width
`define PTR_W               10          // committed pointers, extra bit for full vs empty

// read requests
`define MAX_RD_QWORDS       32          // largest single host read
`define QW_CNT_W            9           // width of a qword count
`define NUM_TAGS            4           // outstanding requests
`define TAG_W               2           // tag width

// completion tlp codes
`define CPL_W_DATA_FMT_TYPE 7'b1001010  // CplD, 3dw header with data
`define CPL_SC              3'b000      // successful completion

`endif

/* source/txbuf_pkg.sv */
// tx buffer fill types shared by request generator, tag table and completion writer
`include "txbuf_defs.svh"

package txbuf_pkg;

    // request as issued to the host
    typedef struct packed {
        logic [`TAG_W-1:0]      tag;
        logic [`PTR_W-1:0]      bram_addr;   // buffer start of the request
        logic [`QW_CNT_W-1:0]   qwords;
    } rd_req_t;

    // one finished completion tlp
    typedef struct packed {
        logic [`TAG_W-1:0]      tag;
        logic [`QW_CNT_W-1:0]   qwords;
    } cpl_done_t;

    // first beat, header dw0 in the upper half and dw1 in the lower half
    typedef struct packed {
        logic                   rsvd0;
        logic [6:0]             fmt_type;
        logic [13:0]            tc_attr;     // tc, td, ep, attr and reserved bits
        logic [9:0]             length;      // dwords
        logic [15:0]            cpl_id;
        logic [2:0]             status;
        logic                   bcm;
        logic [11:0]            byte_count;
    } cpl_hdr0_t;

    // second beat, header dw2 and the first data dword
    typedef struct packed {
        logic [15:0]            req_id;
        logic [7:0]             tag;
        logic                   rsvd1;
        logic [6:0]             lower_addr;
        logic [31:0]            data;
    } cpl_hdr1_t;

    typedef union packed {
        cpl_hdr0_t              hdr0;
        cpl_hdr1_t              hdr1;
    } cpl_beat_u;

endpackage

/* source/rd_request_gen.sv */
// read request generator, issues host page reads sized against free tx buffer space
`timescale 1ns/10ps
`include "txbuf_defs.svh"

module rd_request_gen import txbuf_pkg::*; (
    input  logic                    trn_clk,
    input  logic                    reset,
    input  logic [63:0]             page_addr,
    input  logic [31:0]             page_qwords,
    input  logic                    page_valid,
    output logic                    page_done,
    input  logic [`PTR_W-1:0]       commited_rd_addr,
    output logic                    read_chunk,
    output logic [63:0]             read_addr,
    output logic [`QW_CNT_W-1:0]    qwords_to_rd,
    input  logic [`TAG_W-1:0]       tlp_tag,
    input  logic                    read_chunk_ack,
    input  logic                    retire,
    output logic                    issue,
    output rd_req_t                 issue_req
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_SIZE  = 2'd1;
    localparam logic [1:0] S_CHECK = 2'd2;
    localparam logic [1:0] S_ACK   = 2'd3;

    localparam logic [`QW_CNT_W-1:0] MAX_RD = `MAX_RD_QWORDS;

    logic [1:0]             state;
    logic [31:0]            remaining;      // qwords of the page not yet requested
    logic [`PTR_W-1:0]      next_wr_ptr;    // buffer position of the next request
    logic [2:0]             outstanding;
    logic [`PTR_W-1:0]      occupancy;
    logic [`PTR_W:0]        fill_after;
    logic [`PTR_W-1:0]      step_ptr;
    logic [63:0]            step_bytes;
    logic [31:0]            step_qw;
    logic                   can_issue;
    logic                   taken;

    assign step_ptr   = {{(`PTR_W-`QW_CNT_W){1'b0}}, qwords_to_rd};
    assign step_bytes = {{(61-`QW_CNT_W){1'b0}}, qwords_to_rd, 3'b000};
    assign step_qw    = {{(32-`QW_CNT_W){1'b0}}, qwords_to_rd};

    assign occupancy  = next_wr_ptr - commited_rd_addr;
    assign fill_after = {1'b0, occupancy} + {1'b0, step_ptr};   // occupancy once this lands
    assign can_issue  = (fill_after <= `BUF_QWORDS) && (outstanding < `NUM_TAGS);
    assign taken      = read_chunk && read_chunk_ack;

    // issued minus retired
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            outstanding <= 3'd0;
        end else if (taken && !retire) begin
            outstanding <= outstanding + 3'd1;
        end else if (retire && !taken) begin
            outstanding <= outstanding - 3'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // request fsm
    ////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state       <= S_IDLE;
            read_chunk  <= 1'b0;
            page_done   <= 1'b0;
            issue       <= 1'b0;
            remaining   <= 32'd0;
            next_wr_ptr <= '0;
        end else begin
            page_done <= 1'b0;
            issue     <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (page_valid) begin
                        read_addr <= page_addr;
                        remaining <= page_qwords;
                        state     <= S_SIZE;
                    end
                end
                S_SIZE: begin
                    if (remaining > `MAX_RD_QWORDS) begin
                        qwords_to_rd <= MAX_RD;
                    end else begin
                        qwords_to_rd <= remaining[`QW_CNT_W-1:0];   // tail of the page
                    end
                    if (remaining == 32'd0) begin
                        page_done <= 1'b1;
                        state     <= S_IDLE;
                    end else begin
                        state <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (can_issue) begin    // room and a free tag
                        read_chunk <= 1'b1;
                        state      <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (read_chunk_ack) begin
                        read_chunk          <= 1'b0;
                        issue               <= 1'b1;
                        issue_req.tag       <= tlp_tag;
                        issue_req.bram_addr <= next_wr_ptr;
                        issue_req.qwords    <= qwords_to_rd;
                        next_wr_ptr         <= next_wr_ptr + step_ptr;
                        read_addr           <= read_addr + step_bytes;
                        remaining           <= remaining - step_qw;
                        state               <= S_SIZE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/tag_table.sv */
// tag table, per-tag request records and in-order commit of the buffer write pointer
`timescale 1ns/10ps
`include "txbuf_defs.svh"

module tag_table import txbuf_pkg::*; (
    input  logic                    trn_clk,
    input  logic                    reset,
    input  logic                    issue,
    input  rd_req_t                 issue_req,
    input  logic [`TAG_W-1:0]       lookup_tag,
    output logic [`BUF_ADDR_W-1:0]  lookup_addr,
    input  logic                    done,
    input  cpl_done_t               done_info,
    output logic                    retire,
    output logic [`PTR_W-1:0]       commited_wr_addr
);

    logic [`PTR_W-1:0]      run_addr [`NUM_TAGS];     // next buffer address of each tag
    logic [`QW_CNT_W-1:0]   req_size [`NUM_TAGS];
    logic [`QW_CNT_W-1:0]   rcv_size [`NUM_TAGS];
    logic [`TAG_W-1:0]      issue_order [`NUM_TAGS];  // tags in the order they went out
    logic [`NUM_TAGS-1:0]   pending;
    logic [`TAG_W-1:0]      order_wr;
    logic [`TAG_W-1:0]      order_rd;                 // commit pointer
    logic [`TAG_W-1:0]      head_tag;
    logic                   head_ready;
    logic [`PTR_W-1:0]      done_step;

    assign lookup_addr = run_addr[lookup_tag][`BUF_ADDR_W-1:0];
    assign done_step   = {{(`PTR_W-`QW_CNT_W){1'b0}}, done_info.qwords};

    // oldest request fully received
    assign head_tag   = issue_order[order_rd];
    assign head_ready = pending[head_tag] && (rcv_size[head_tag] == req_size[head_tag]);

    ////////////////////////////////////////////////////////////
    // request records
    ////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (issue) begin
            run_addr[issue_req.tag]  <= issue_req.bram_addr;
            req_size[issue_req.tag]  <= issue_req.qwords;
            rcv_size[issue_req.tag]  <= '0;
            issue_order[order_wr]    <= issue_req.tag;
        end
        if (done) begin     // a completion may cover part of a request
            run_addr[done_info.tag] <= run_addr[done_info.tag] + done_step;
            rcv_size[done_info.tag] <= rcv_size[done_info.tag] + done_info.qwords;
        end
    end

    ////////////////////////////////////////////////////////////
    // commit in issue order
    ////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            pending          <= '0;
            order_wr         <= '0;
            order_rd         <= '0;
            retire           <= 1'b0;
            commited_wr_addr <= '0;
        end else begin
            retire <= 1'b0;
            if (issue) begin
                pending[issue_req.tag] <= 1'b1;
                order_wr               <= order_wr + 1'b1;
            end
            if (head_ready) begin
                pending[head_tag] <= 1'b0;      // tag free for the host again
                order_rd          <= order_rd + 1'b1;
                retire            <= 1'b1;
                commited_wr_addr  <= run_addr[head_tag];   // end of the request
            end
        end
    end

endmodule

/* source/cpl_writer.sv */
// completion writer, parses CplD TLPs and writes realigned byte-swapped qwords to the buffer
`timescale 1ns/10ps
`include "txbuf_defs.svh"

module cpl_writer import txbuf_pkg::*; (
    input  logic                    trn_clk,
    input  logic                    reset,
    input  logic [63:0]             trn_rd,
    input  logic                    trn_rsof_n,
    input  logic                    trn_reof_n,
    input  logic                    trn_rsrc_rdy_n,
    output logic                    trn_rdst_rdy_n,
    output logic [`TAG_W-1:0]       lookup_tag,
    input  logic [`BUF_ADDR_W-1:0]  lookup_addr,
    output logic                    done,
    output cpl_done_t               done_info,
    output logic [`BUF_ADDR_W-1:0]  wr_addr,
    output logic [63:0]             wr_data,
    output logic                    wr_en
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_HDR1 = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;
    localparam logic [1:0] S_SKIP = 2'd3;

    cpl_beat_u              beat;
    logic [1:0]             state;
    logic                   beat_valid;
    logic                   is_cpl_sc;
    logic [31:0]            held_dw;        // dword waiting for its upper half
    logic [`BUF_ADDR_W-1:0] cur_addr;
    logic [`TAG_W-1:0]      cur_tag;
    logic [`QW_CNT_W-1:0]   cur_qwords;

    function automatic logic [31:0] swap_dw(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    assign beat           = trn_rd;
    assign beat_valid     = !trn_rsrc_rdy_n;
    assign trn_rdst_rdy_n = 1'b0;           // completions are never throttled
    assign lookup_tag     = beat.hdr1.tag[`TAG_W-1:0];
    assign is_cpl_sc      = (beat.hdr0.fmt_type == `CPL_W_DATA_FMT_TYPE) &&
                            (beat.hdr0.status == `CPL_SC);

    ////////////////////////////////////////////////////////////
    // completion fsm
    ////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state <= S_IDLE;
            wr_en <= 1'b0;
            done  <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            done  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (beat_valid && !trn_rsof_n) begin
                        cur_qwords <= beat.hdr0.length[`QW_CNT_W:1];   // even dword count
                        if (is_cpl_sc) begin
                            state <= S_HDR1;
                        end else if (trn_reof_n) begin
                            state <= S_SKIP;    // drop the rest of this tlp
                        end
                    end
                end
                S_HDR1: begin
                    if (beat_valid) begin
                        cur_tag  <= lookup_tag;
                        cur_addr <= lookup_addr;
                        held_dw  <= beat.hdr1.data;
                        state    <= S_DATA;
                    end
                end
                S_DATA: begin
                    // the eof beat's write completes the last held dword
                    if (beat_valid) begin
                        wr_en    <= 1'b1;
                        wr_addr  <= cur_addr;
                        wr_data  <= {swap_dw(trn_rd[63:32]), swap_dw(held_dw)};
                        held_dw  <= trn_rd[31:0];
                        cur_addr <= cur_addr + 1'b1;
                        if (!trn_reof_n) begin
                            done             <= 1'b1;
                            done_info.tag    <= cur_tag;
                            done_info.qwords <= cur_qwords;
                            state            <= S_IDLE;
                        end
                    end
                end
                S_SKIP: begin
                    if (beat_valid && !trn_reof_n) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/tx_buffer_fill.sv */
// tx buffer fill top, refills the on-chip tx buffer from one host page
`timescale 1ns/10ps
`include "txbuf_defs.svh"

module tx_buffer_fill import txbuf_pkg::*; (
    input  logic                    trn_clk,
    input  logic                    reset,
    input  logic [63:0]             trn_rd,
    input  logic                    trn_rsof_n,
    input  logic                    trn_reof_n,
    input  logic                    trn_rsrc_rdy_n,
    output logic                    trn_rdst_rdy_n,
    input  logic [63:0]             page_addr,
    input  logic [31:0]             page_qwords,
    input  logic                    page_valid,
    output logic                    page_done,
    output logic                    read_chunk,
    output logic [63:0]             read_addr,
    output logic [`QW_CNT_W-1:0]    qwords_to_rd,
    input  logic [`TAG_W-1:0]       tlp_tag,
    input  logic                    read_chunk_ack,
    output logic [`BUF_ADDR_W-1:0]  wr_addr,
    output logic [63:0]             wr_data,
    output logic                    wr_en,
    input  logic [`PTR_W-1:0]       commited_rd_addr,
    output logic [`PTR_W-1:0]       commited_wr_addr
);

    logic                   issue;
    rd_req_t                issue_req;
    logic                   retire;
    logic [`TAG_W-1:0]      lookup_tag;
    logic [`BUF_ADDR_W-1:0] lookup_addr;
    logic                   done;
    cpl_done_t              done_info;

    rd_request_gen req_gen0 (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .page_addr        (page_addr),
        .page_qwords      (page_qwords),
        .page_valid       (page_valid),
        .page_done        (page_done),
        .commited_rd_addr (commited_rd_addr),
        .read_chunk       (read_chunk),
        .read_addr        (read_addr),
        .qwords_to_rd     (qwords_to_rd),
        .tlp_tag          (tlp_tag),
        .read_chunk_ack   (read_chunk_ack),
        .retire           (retire),
        .issue            (issue),
        .issue_req        (issue_req)
    );

    tag_table tags0 (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .issue            (issue),
        .issue_req        (issue_req),
        .lookup_tag       (lookup_tag),
        .lookup_addr      (lookup_addr),
        .done             (done),
        .done_info        (done_info),
        .retire           (retire),
        .commited_wr_addr (commited_wr_addr)
    );

    cpl_writer cpl0 (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .trn_rd           (trn_rd),
        .trn_rsof_n       (trn_rsof_n),
        .trn_reof_n       (trn_reof_n),
        .trn_rsrc_rdy_n   (trn_rsrc_rdy_n),
        .trn_rdst_rdy_n   (trn_rdst_rdy_n),
        .lookup_tag       (lookup_tag),
        .lookup_addr      (lookup_addr),
        .done             (done),
        .done_info        (done_info),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .wr_en            (wr_en)
    );

endmodule

/* bench/tx_fill_sva.sv */
// tx buffer fill assertions on request handshake hold and the outstanding request limit
`timescale 1ns/10ps
`include "txbuf_defs.svh"

module tx_fill_sva (
    input logic                     trn_clk,
    input logic                     reset,
    input logic                     read_chunk,
    input logic                     read_chunk_ack,
    input logic [`QW_CNT_W-1:0]     qwords_to_rd,
    input logic [63:0]              read_addr,
    input logic [`PTR_W-1:0]        commited_wr_addr
);

    logic [3:0]             outstanding;    // accepted requests not yet committed
    logic [`PTR_W-1:0]      prev_wr_addr;
    logic                   taken;
    logic                   committed;
    int                     fail_count = 0;

    assign taken     = read_chunk && read_chunk_ack;
    assign committed = (commited_wr_addr != prev_wr_addr);    // each commit moves the pointer

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            outstanding  <= 4'd0;
            prev_wr_addr <= '0;
        end else begin
            prev_wr_addr <= commited_wr_addr;
            outstanding  <= outstanding + {3'd0, taken} - {3'd0, committed};
        end
    end

    a_chunk_hold: assert property (@(posedge trn_clk) disable iff (reset)
        read_chunk && !read_chunk_ack |=>
            read_chunk && $stable(qwords_to_rd) && $stable(read_addr))
        else begin
            $error("read_chunk dropped or changed before ack");
            fail_count = fail_count + 1;
        end

    a_outstanding: assert property (@(posedge trn_clk) disable iff (reset)
        outstanding <= `NUM_TAGS)
        else begin
            $error("more than %0d outstanding requests", `NUM_TAGS);
            fail_count = fail_count + 1;
        end

endmodule

bind tx_buffer_fill tx_fill_sva sva0 (
    .trn_clk          (trn_clk),
    .reset            (reset),
    .read_chunk       (read_chunk),
    .read_chunk_ack   (read_chunk_ack),
    .qwords_to_rd     (qwords_to_rd),
    .read_addr        (read_addr),
    .commited_wr_addr (commited_wr_addr)
);

/* bench/tx_fill_checker.sv */
// tx buffer fill checker that predicts requests and buffer writes and compares them at the ports
`timescale 1ns/10ps
`include "txbuf_defs.svh"

module tx_fill_checker (
    input  logic                    trn_clk,
    input  logic                    case_start,
    input  logic                    case_end,
    input  logic [63:0]             page_addr,
    input  logic [31:0]             page_qwords,
    input  logic                    page_done,
    input  logic                    read_chunk,
    input  logic                    read_chunk_ack,
    input  logic [63:0]             read_addr,
    input  logic [`QW_CNT_W-1:0]    qwords_to_rd,
    input  logic [`BUF_ADDR_W-1:0]  wr_addr,
    input  logic [63:0]             wr_data,
    input  logic                    wr_en,
    input  logic                    trn_rdst_rdy_n,
    input  logic [`PTR_W-1:0]       commited_rd_addr,
    input  logic [`PTR_W-1:0]       commited_wr_addr,
    output int                      cases_run,
    output int                      cases_failed,
    output int                      errors
);

    logic [63:0]    exp_mem [`BUF_QWORDS];
    logic           exp_valid [`BUF_QWORDS];
    logic [63:0]    case_addr;
    int             case_qwords;
    int             issued_qw;      // qwords requested so far in this case
    int             writes;
    int             done_pulses;
    int             case_errors;
    int             left;
    int             exp_size;
    int             occ;
    int             pos;
    logic [31:0]    dw_lo;

    initial begin
        cases_run    = 0;
        cases_failed = 0;
        errors       = 0;
    end

    // host dwords arrive big endian
    function automatic logic [31:0] byte_swap(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors      = errors + 1;
        case_errors = case_errors + 1;
    endtask

    always @(posedge trn_clk) begin
        if (case_start) begin
            case_addr   = page_addr;
            case_qwords = page_qwords;
            issued_qw   = 0;
            writes      = 0;
            done_pulses = 0;
            case_errors = 0;
            for (int i = 0; i < `BUF_QWORDS; i++) begin
                exp_valid[i] = 1'b0;
            end
        end else if (case_end) begin
            if (issued_qw != case_qwords)
                report_error($sformatf("requested %0d qwords, page has %0d", issued_qw,
                                       case_qwords));
            if (done_pulses != 1)
                report_error($sformatf("page_done pulsed %0d times", done_pulses));
            if (writes != case_qwords)
                report_error($sformatf("%0d buffer writes, expected %0d", writes,
                                       case_qwords));
            if (commited_wr_addr != case_qwords % 1024)
                report_error($sformatf("commited_wr_addr %0d, expected %0d",
                                       commited_wr_addr, case_qwords % 1024));
            cases_run = cases_run + 1;
            if (case_errors == 0) begin
                $display("case %0d: %0d qwords ok", cases_run - 1, case_qwords);
            end else begin
                cases_failed = cases_failed + 1;
                $display("case %0d: failed with %0d errors", cases_run - 1, case_errors);
            end
        end else begin
            if (trn_rdst_rdy_n !== 1'b0)
                report_error("trn_rdst_rdy_n high, completions throttled");
            if (read_chunk && read_chunk_ack) begin
                left     = case_qwords - issued_qw;
                exp_size = (left > `MAX_RD_QWORDS) ? `MAX_RD_QWORDS : left;
                if (qwords_to_rd != exp_size)
                    report_error($sformatf("request of %0d qwords, expected %0d",
                                           qwords_to_rd, exp_size));
                if (read_addr != case_addr + 64'(issued_qw) * 8)
                    report_error($sformatf("read_addr %h, expected %h", read_addr,
                                           case_addr + 64'(issued_qw) * 8));
                occ = ((issued_qw - commited_rd_addr) & 1023) + qwords_to_rd;
                if (occ > `BUF_QWORDS)
                    report_error($sformatf("request would fill buffer to %0d", occ));
                for (int j = 0; j < qwords_to_rd; j++) begin
                    pos            = (issued_qw + j) % `BUF_QWORDS;
                    dw_lo          = read_addr[31:0] + 32'(2 * j);
                    exp_mem[pos]   = {byte_swap(dw_lo + 32'd1), byte_swap(dw_lo)};
                    exp_valid[pos] = 1'b1;
                end
                issued_qw = issued_qw + qwords_to_rd;
            end
            if (wr_en) begin
                writes = writes + 1;
                if (!exp_valid[wr_addr]) begin
                    report_error($sformatf("unexpected write to buffer address %0d", wr_addr));
                end else begin
                    if (wr_data != exp_mem[wr_addr])
                        report_error($sformatf("buffer[%0d] written %h, expected %h",
                                               wr_addr, wr_data, exp_mem[wr_addr]));
                    exp_valid[wr_addr] = 1'b0;
                end
            end
            if (page_done)
                done_pulses = done_pulses + 1;
        end
    end

endmodule

/* bench/tb_tx_buffer_fill.sv */
// tx buffer fill testbench with a host read model, completion return and a case table
`timescale 1ns/10ps
`include "txbuf_defs.svh"

module tb_tx_buffer_fill;

    typedef struct packed {
        logic [63:0]    addr;
        logic [31:0]    qwords;
        logic           reversed;   // return completions in reverse tag order
        logic           drain;      // consumer follows commited_wr_addr
        logic           inject;     // send bad completions first
    } fill_case_t;

    typedef struct packed {
        logic [63:0]            addr;
        logic [`QW_CNT_W-1:0]   qwords;
        logic [`TAG_W-1:0]      tag;
    } host_req_t;

    localparam int NUM_CASES = 5;

    logic                   trn_clk = 1'b0;
    logic                   reset = 1'b1;
    logic [63:0]            trn_rd = '0;
    logic                   trn_rsof_n = 1'b1;
    logic                   trn_reof_n = 1'b1;
    logic                   trn_rsrc_rdy_n = 1'b1;
    logic                   trn_rdst_rdy_n;
    logic [63:0]            page_addr = '0;
    logic [31:0]            page_qwords = '0;
    logic                   page_valid = 1'b0;
    logic                   page_done;
    logic                   read_chunk;
    logic [63:0]            read_addr;
    logic [`QW_CNT_W-1:0]   qwords_to_rd;
    logic [`TAG_W-1:0]      tlp_tag = '0;
    logic                   read_chunk_ack = 1'b0;
    logic [`BUF_ADDR_W-1:0] wr_addr;
    logic [63:0]            wr_data;
    logic                   wr_en;
    logic [`PTR_W-1:0]      commited_rd_addr = '0;
    logic [`PTR_W-1:0]      commited_wr_addr;

    fill_case_t             cases [NUM_CASES];
    host_req_t              pend_q [$];     // accepted requests awaiting completion
    host_req_t              batch [$];
    host_req_t              req;
    host_req_t              cpl_req;
    logic [`TAG_W-1:0]      tag_next = '0;
    int                     idle_cycles = 0;
    logic                   drain_on = 1'b0;
    logic                   reversed = 1'b0;
    logic                   inject_pending = 1'b0;
    logic                   sender_busy = 1'b0;
    logic                   case_start = 1'b0;
    logic                   case_end = 1'b0;
    integer                 seed = 23;
    int                     cycle_count = 0;
    int                     cycle_limit;
    int                     total_qwords;
    int                     cases_run;
    int                     cases_failed;
    int                     errors;

    always #4 trn_clk = ~trn_clk;

    tx_buffer_fill dut0 (.*);

    tx_fill_checker chk0 (.*);

    ////////////////////////////////////////////////////////////
    // host request side with round-robin tags
    ////////////////////////////////////////////////////////////
    always @(posedge trn_clk) begin
        if (reset) begin
            read_chunk_ack <= 1'b0;
            tag_next       <= '0;
            idle_cycles    <= 0;
        end else if (read_chunk && read_chunk_ack) begin
            req.addr   = read_addr;
            req.qwords = qwords_to_rd;
            req.tag    = tlp_tag;
            pend_q.push_back(req);
            read_chunk_ack <= 1'b0;
            tag_next       <= tag_next + 1'b1;
            idle_cycles    <= 0;
        end else begin
            if (read_chunk) begin
                read_chunk_ack <= 1'b1;
                tlp_tag        <= tag_next;
            end
            idle_cycles <= idle_cycles + 1;
        end
    end

    task automatic drive_beat(input logic [63:0] word, input logic sof, input logic eof);
        int gap;
        gap = {$random(seed)} % 3;
        repeat (gap) begin
            @(posedge trn_clk);
            trn_rsrc_rdy_n <= 1'b1;
        end
        @(posedge trn_clk);
        trn_rd         <= word;
        trn_rsof_n     <= !sof;
        trn_reof_n     <= !eof;
        trn_rsrc_rdy_n <= 1'b0;
    endtask

    // dword k of host address a carries a + k
    task automatic send_cpl(input logic [63:0] a, input int qw, input logic [1:0] tag,
                            input logic [2:0] status, input logic [6:0] fmt);
        logic [31:0] base;
        logic [9:0]  len;
        logic [11:0] bytes;
        int          nb;
        base  = a[31:0];
        len   = 10'(qw * 2);
        bytes = 12'(qw * 8);
        nb    = qw + 2;
        drive_beat({1'b0, fmt, 14'd0, len, 16'h0100, status, 1'b0, bytes}, 1'b1, 1'b0);
        drive_beat({16'h0000, 6'd0, tag, 1'b0, 7'd0, base}, 1'b0, 1'b0);
        for (int b = 2; b < nb; b++) begin
            drive_beat({base + 32'(2 * (b - 2) + 1), base + 32'(2 * (b - 2) + 2)},
                       1'b0, b == nb - 1);
        end
        @(posedge trn_clk);
        trn_rsrc_rdy_n <= 1'b1;
        trn_rsof_n     <= 1'b1;
        trn_reof_n     <= 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // host completion side
    ////////////////////////////////////////////////////////////
    always begin
        @(posedge trn_clk);
        if (inject_pending) begin
            sender_busy = 1'b1;
            send_cpl(64'h0000_0000_0bad_0000, 4, 2'd0, 3'b001, `CPL_W_DATA_FMT_TYPE);
            send_cpl(64'h0000_0000_0bad_1000, 4, 2'd1, `CPL_SC, 7'b1000000);
            inject_pending <= 1'b0;
            sender_busy    = 1'b0;
        end else if (pend_q.size() > 0 && (pend_q.size() >= `NUM_TAGS || idle_cycles >= 16)) begin
            sender_busy = 1'b1;
            batch = pend_q;
            pend_q.delete();
            for (int i = 0; i < batch.size(); i++) begin
                cpl_req = reversed ? batch[batch.size() - 1 - i] : batch[i];
                send_cpl(cpl_req.addr, cpl_req.qwords, cpl_req.tag, `CPL_SC,
                         `CPL_W_DATA_FMT_TYPE);
            end
            sender_busy = 1'b0;
        end
    end

    // buffer consumer reads everything committed
    always @(posedge trn_clk) begin
        if (reset)
            commited_rd_addr <= '0;
        else if (drain_on)
            commited_rd_addr <= commited_wr_addr;
    end

    always @(posedge trn_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        cases[0] = '{64'h0000_0001_0000_0000, 32'd40,  1'b0, 1'b1, 1'b0};
        cases[1] = '{64'h0000_0000_2000_0800, 32'd100, 1'b1, 1'b1, 1'b0};
        cases[2] = '{64'h0000_0003_4000_0000, 32'd600, 1'b0, 1'b0, 1'b0};   // stalls at full
        cases[3] = '{64'h0000_0000_0000_6000, 32'd16,  1'b0, 1'b1, 1'b1};
        cases[4] = '{64'h0000_0000_7fff_f000, 32'd75,  1'b1, 1'b1, 1'b1};
        total_qwords = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            total_qwords = total_qwords + cases[i].qwords;
        end
        cycle_limit = total_qwords * 8 + 200;

        for (int c = 0; c < NUM_CASES; c++) begin
            @(posedge trn_clk);
            reset    <= 1'b1;
            drain_on <= 1'b0;
            repeat (5) @(posedge trn_clk);
            reset          <= 1'b0;
            page_addr      <= cases[c].addr;
            page_qwords    <= cases[c].qwords;
            reversed       <= cases[c].reversed;
            drain_on       <= cases[c].drain;
            inject_pending <= cases[c].inject;
            @(posedge trn_clk);
            case_start <= 1'b1;
            page_valid <= 1'b1;
            @(posedge trn_clk);
            case_start <= 1'b0;
            page_valid <= 1'b0;
            if (!cases[c].drain) begin
                while (commited_wr_addr != `BUF_QWORDS) @(posedge trn_clk);
                repeat (20) @(posedge trn_clk);
                drain_on <= 1'b1;   // release the consumer
            end
            while (!(commited_wr_addr == cases[c].qwords % 1024 && pend_q.size() == 0 &&
                     !sender_busy && !inject_pending))
                @(posedge trn_clk);
            repeat (4) @(posedge trn_clk);
            case_end <= 1'b1;
            @(posedge trn_clk);
            case_end <= 1'b0;
        end

        repeat (2) @(posedge trn_clk);
        $display("cases run %0d, failed %0d, errors %0d, assertion failures %0d", cases_run,
                 cases_failed, errors, dut0.sva0.fail_count);
        if (errors == 0 && dut0.sva0.fail_count == 0 && cases_run == NUM_CASES) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+source
source/txbuf_pkg.sv
source/rd_request_gen.sv
source/tag_table.sv
source/cpl_writer.sv
source/tx_buffer_fill.sv
bench/tx_fill_sva.sv
bench/tx_fill_checker.sv
bench/tb_tx_buffer_fill.sv
